//--- compile.f
+incdir+include
hw/l1i_pkg.sv
hw/l1i_tag_array.sv
hw/l1i_data_array.sv
hw/l1i_lru.sv
hw/l1i_ctrl.sv
hw/l1i_top.sv
bench/l1i_asserts.sv
bench/tb_l1i.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_l1i
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- bench/l1i_stimulus.txt
# address  expected_word  miss(0/1)  mau_delay in cycles (-1 = random 0..7)
# address and word in hex, one access per line
00001000 00001000 1 0
00001000 00001000 0 0
00001004 00001004 0 0
00001008 00001008 0 0
0000100c 0000100c 0 0
00002010 00002010 1 2
00003010 00003010 1 0
00004010 00004010 1 1
00005010 00005010 1 3
00006010 00006010 1 0
00002010 00002010 1 0
00005010 00005010 0 0
00006010 00006010 0 0
00002010 00002010 0 0
00003010 00003010 1 0
00004010 00004010 1 0
00007020 00007020 1 -1
00007024 00007024 0 -1
00008028 00008028 1 -1
0000902c 0000902c 1 5
00007020 00007020 0 -1
0000a030 0000a030 1 -1
0000a03c 0000a03c 0 -1
0000a038 0000a038 0 -1

//--- bench/tb_l1i.sv
// ----------------------------
// L1I testbench
// File driven fetches against a MAU memory model
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module tb_l1i;

	localparam int    CLK_PERIOD     = 40;
	localparam int    DRIVE_DLY      = 2;
	localparam int    RST_CYCLES     = 10;
	localparam int    HIT_LATENCY    = 1;
	localparam int    WD_PER_ACCESS  = 20;
	localparam int    WD_MARGIN      = 50;
	localparam string STIM_FILE      = "bench/l1i_stimulus.txt";

	logic                          clk;
	logic                          rst_n;
	logic                          core_req_val;
	logic [`CORE_ADDR_WIDTH-1:0]   core_req_addr;
	logic                          core_req_ack;
	logic [`CORE_DATA_WIDTH-1:0]   core_ack_data;
	logic                          mau_req_val;
	logic [`CORE_ADDR_WIDTH-1:0]   mau_req_addr;
	logic                          mau_req_ack;
	logic [`L1_LINE_SIZE-1:0]      mau_ack_data;

	// Stimulus table
	logic [31:0]   stim_addr [$];
	logic [31:0]   stim_data [$];
	logic [31:0]   stim_miss [$];
	int            stim_delay [$];
	bit            stim_loaded;

	// Shared with the MAU model
	int            mau_delay;
	int            mau_req_cnt;
	logic [31:0]   mau_addr_seen;

	l1i_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.core_req_val  (core_req_val),
		.core_req_addr (core_req_addr),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.mau_req_val   (mau_req_val),
		.mau_req_addr  (mau_req_addr),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Every word of a line holds its own byte address
	function automatic logic [`L1_LINE_SIZE-1:0] build_line(input logic [31:0] line_addr);
		logic [`L1_LINE_SIZE-1:0] data;
		data = '0;
		for (int i = 0; i < `L1_LINE_SIZE / 32; i++)
			data[i*32 +: 32] = (line_addr & ~32'hf) + 32'(i * 4);
		return data;
	endfunction

	task automatic load_stimulus();
		int          fd;
		int          cnt;
		string       text;
		logic [31:0] addr;
		logic [31:0] data;
		int          miss;
		int          delay;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			$display("tests failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			cnt = $fgets(text, fd);
			if (cnt > 0 && text.getc(0) != "#") begin
				cnt = $sscanf(text, "%h %h %d %d", addr, data, miss, delay);
				if (cnt == 4) begin
					stim_addr.push_back(addr);
					stim_data.push_back(data);
					stim_miss.push_back(miss);
					stim_delay.push_back(delay);
				end
			end
		end
		$fclose(fd);
		check("stimulus entries present", 32'd1, 32'(stim_addr.size() > 0));
	endtask

	// One fetch, held until the ack is seen at a rising edge
	task automatic run_access(input int n);
		string       name;
		logic [31:0] addr;
		logic [31:0] got_data;
		int          req_before;
		int          cycles;
		bit          ack_seen;
		addr = stim_addr[n];
		name = $sformatf("access %0d addr %h", n, addr);
		mau_delay = stim_delay[n];
		req_before = mau_req_cnt;
		@(posedge clk);
		#DRIVE_DLY;
		core_req_val = 1'b1;
		core_req_addr = addr;
		cycles = 0;
		ack_seen = 1'b0;
		got_data = '0;
		while (!ack_seen) begin
			@(negedge clk);
			cycles++;
			if (core_req_ack) begin
				ack_seen = 1'b1;
				got_data = core_ack_data;
			end
		end
		@(posedge clk);
		#DRIVE_DLY;
		core_req_val = 1'b0;
		check({name, " data"}, stim_data[n], got_data);
		check({name, " miss"}, stim_miss[n], 32'(mau_req_cnt - req_before));
		if (stim_miss[n] != 0)
			check({name, " mau addr"}, addr & ~32'hf, mau_addr_seen);
		else
			check({name, " hit latency"}, 32'(1 + HIT_LATENCY), 32'(cycles));
	endtask

	// ----------------------------
	// MAU memory model
	// ----------------------------
	initial begin : mau_model
		int          wait_cycles;
		logic [31:0] addr_held;
		// Random delays are drawn in this process
		void'($urandom(32'h518));
		mau_req_ack = 1'b0;
		mau_ack_data = '0;
		mau_req_cnt = 0;
		mau_addr_seen = '0;
		forever begin
			@(negedge clk);
			if (mau_req_val === 1'b1) begin
				mau_req_cnt++;
				addr_held = mau_req_addr;
				mau_addr_seen = addr_held;
				wait_cycles = (mau_delay < 0) ? int'($urandom % 8) : mau_delay;
				repeat (wait_cycles) begin
					@(negedge clk);
					check("mau_req_val held", 32'd1, 32'(mau_req_val));
					check("mau_req_addr held", addr_held, mau_req_addr);
				end
				@(posedge clk);
				#DRIVE_DLY;
				mau_req_ack = 1'b1;
				mau_ack_data = build_line(addr_held);
				@(posedge clk);
				#DRIVE_DLY;
				mau_req_ack = 1'b0;
				mau_ack_data = '0;
			end
		end
	end

	initial begin : watchdog
		int limit_cycles;
		wait (stim_loaded);
		limit_cycles = stim_addr.size() * WD_PER_ACCESS + `L1_SET_NUM + WD_MARGIN;
		#(limit_cycles * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the cache stopped answering",
			limit_cycles);
		$display("tests failed");
		$fatal(1);
	end

	// ----------------------------
	// Main sequence
	// ----------------------------
	initial begin : main_seq
		rst_n = 1'b0;
		core_req_val = 1'b0;
		core_req_addr = '0;
		mau_delay = 0;
		stim_loaded = 1'b0;
		load_stimulus();
		stim_loaded = 1'b1;

		repeat (RST_CYCLES) begin
			@(negedge clk);
			check("reset core ack", 32'd0, 32'(core_req_ack));
			check("reset mau req", 32'd0, 32'(mau_req_val));
		end
		@(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		// Request held high through the sweep must not be taken
		core_req_val = 1'b1;
		core_req_addr = stim_addr[0];
		repeat (`L1_SET_NUM) begin
			@(negedge clk);
			check("init core ack", 32'd0, 32'(core_req_ack));
			check("init mau req", 32'd0, 32'(mau_req_val));
		end

		for (int n = 0; n < stim_addr.size(); n++)
			run_access(n);

		$display("all tests passed");
		$finish;
	end

endmodule

//--- bench/l1i_asserts.sv
// ----------------------------
// L1I interface assertions
// Core and MAU handshake rules
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module l1i_asserts
	import l1i_pkg::*;
(
	input logic                          clk,
	input logic                          rst_n,
	input logic                          core_req_val,
	input logic [`CORE_ADDR_WIDTH-1:0]   core_req_addr,
	input logic                          core_req_ack,
	input logic                          mau_req_val,
	input logic [`CORE_ADDR_WIDTH-1:0]   mau_req_addr,
	input logic                          mau_req_ack,
	input l1i_state_e                    state
);

	// MAU request held with a fixed address until acked
	mau_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_val && !mau_req_ack |=> mau_req_val && $stable(mau_req_addr))
		else $error("MAU request dropped or changed before ack");

	// Core ack is a single cycle pulse
	ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_ack |=> !core_req_ack)
		else $error("core ack held longer than one cycle");

	word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_val |-> (core_req_addr[1:0] == 2'b00))
		else $error("core fetch address not word aligned");

	// Nothing leaves the cache during the init sweep
	quiet_init: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_INIT) |-> !core_req_ack && !mau_req_val)
		else $error("ack or MAU request during init sweep");

endmodule

bind l1i_top l1i_asserts u_asserts (
	.clk           (clk),
	.rst_n         (rst_n),
	.core_req_val  (core_req_val),
	.core_req_addr (core_req_addr),
	.core_req_ack  (core_req_ack),
	.mau_req_val   (mau_req_val),
	.mau_req_addr  (mau_req_addr),
	.mau_req_ack   (mau_req_ack),
	.state         (u_ctrl.state)
);

//--- hw/l1i_top.sv
// ----------------------------
// L1I top
// Read-only 4-way instruction cache
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module l1i_top
	import l1i_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          core_req_val,
	input  logic [`CORE_ADDR_WIDTH-1:0]   core_req_addr,
	output logic                          core_req_ack,
	output logic [`CORE_DATA_WIDTH-1:0]   core_ack_data,
	output logic                          mau_req_val,
	output logic [`CORE_ADDR_WIDTH-1:0]   mau_req_addr,
	input  logic                          mau_req_ack,
	input  logic [`L1_LINE_SIZE-1:0]      mau_ack_data
);

	l1i_lookup_t                    lookup;
	logic [`L1_WAY_IDX_WIDTH-1:0]   victim_way;
	logic [`L1_LINE_SIZE-1:0]       rd_line;
	logic                           rd_en;
	logic [`CORE_IDX_WIDTH-1:0]     rd_idx;
	logic [`CORE_TAG_WIDTH-1:0]     req_tag;
	logic                           clr_en;
	logic [`CORE_IDX_WIDTH-1:0]     clr_idx;
	logic                           fill_we;
	logic [`L1_WAY_IDX_WIDTH-1:0]   fill_way;
	logic                           touch;
	logic [`L1_WAY_IDX_WIDTH-1:0]   touch_way;

	l1i_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.core_req_val  (core_req_val),
		.core_req_addr (core_req_addr),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.lookup        (lookup),
		.victim_way    (victim_way),
		.rd_line       (rd_line),
		.mau_req_val   (mau_req_val),
		.mau_req_addr  (mau_req_addr),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data),
		.rd_en         (rd_en),
		.rd_idx        (rd_idx),
		.req_tag       (req_tag),
		.clr_en        (clr_en),
		.clr_idx       (clr_idx),
		.fill_we       (fill_we),
		.fill_way      (fill_way),
		.touch         (touch),
		.touch_way     (touch_way)
	);

	l1i_tag_array u_tag (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_en    (rd_en),
		.rd_idx   (rd_idx),
		.req_tag  (req_tag),
		.clr_en   (clr_en),
		.clr_idx  (clr_idx),
		.fill_we  (fill_we),
		.fill_way (fill_way),
		.lookup   (lookup)
	);

	// Fill data comes straight from the MAU bus
	l1i_data_array u_data (
		.clk       (clk),
		.rd_en     (rd_en),
		.rd_idx    (rd_idx),
		.hit_way   (lookup.hit_way),
		.fill_we   (fill_we),
		.fill_way  (fill_way),
		.fill_data (mau_ack_data),
		.rd_line   (rd_line)
	);

	l1i_lru u_lru (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_en      (rd_en),
		.rd_idx     (rd_idx),
		.clr_en     (clr_en),
		.clr_idx    (clr_idx),
		.lookup     (lookup),
		.touch      (touch),
		.touch_way  (touch_way),
		.victim_way (victim_way)
	);

endmodule

//--- hw/l1i_ctrl.sv
// ----------------------------
// L1I control
// Init sweep, lookup, miss request, fill and core ack
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module l1i_ctrl
	import l1i_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          core_req_val,
	input  logic [`CORE_ADDR_WIDTH-1:0]   core_req_addr,
	output logic                          core_req_ack,
	output logic [`CORE_DATA_WIDTH-1:0]   core_ack_data,
	input  l1i_lookup_t                   lookup,
	input  logic [`L1_WAY_IDX_WIDTH-1:0]  victim_way,
	input  logic [`L1_LINE_SIZE-1:0]      rd_line,
	output logic                          mau_req_val,
	output logic [`CORE_ADDR_WIDTH-1:0]   mau_req_addr,
	input  logic                          mau_req_ack,
	input  logic [`L1_LINE_SIZE-1:0]      mau_ack_data,
	output logic                          rd_en,
	output logic [`CORE_IDX_WIDTH-1:0]    rd_idx,
	output logic [`CORE_TAG_WIDTH-1:0]    req_tag,
	output logic                          clr_en,
	output logic [`CORE_IDX_WIDTH-1:0]    clr_idx,
	output logic                          fill_we,
	output logic [`L1_WAY_IDX_WIDTH-1:0]  fill_way,
	output logic                          touch,
	output logic [`L1_WAY_IDX_WIDTH-1:0]  touch_way
);

	l1i_state_e                          state;
	l1i_state_e                          state_next;
	logic [`CORE_IDX_WIDTH-1:0]          init_cnt;
	logic                                init_done;
	logic                                ack_gap_r;
	l1i_addr_t                           core_addr;
	l1i_addr_t                           req_r;
	l1i_addr_t                           mau_addr;
	logic [`L1_WAY_IDX_WIDTH-1:0]        victim_r;
	logic [`L1_LINE_SIZE-1:0]            fill_line_r;
	logic [`L1_LINE_SIZE-1:0]            ack_line;
	logic [`CORE_OFFSET_WIDTH-3:0]       word_sel;
	logic                                accept;
	logic                                hit_now;
	logic                                miss_now;

	assign core_addr = core_req_addr;
	assign init_done = (init_cnt == `CORE_IDX_WIDTH'(`L1_SET_NUM - 1));

	// Skip one idle cycle after an ack so the held level is not taken twice
	assign accept   = (state == ST_IDLE) && core_req_val && !ack_gap_r;
	assign hit_now  = (state == ST_LOOKUP) && lookup.hit;
	assign miss_now = (state == ST_LOOKUP) && !lookup.hit;

	// ----------------------------
	// FSM
	// ----------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_INIT;
			init_cnt  <= '0;
			ack_gap_r <= 1'b0;
		end else begin
			state     <= state_next;
			ack_gap_r <= core_req_ack;
			if (state == ST_INIT)
				init_cnt <= init_cnt + 1'b1;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_INIT:   if (init_done) state_next = ST_IDLE;
			ST_IDLE:   if (accept) state_next = ST_LOOKUP;
			ST_LOOKUP: begin
				if (lookup.hit)
					state_next = ST_IDLE;
				else if (mau_req_ack)
					state_next = ST_ACK;
				else
					state_next = ST_MISS;
			end
			// Request out, waiting for the line
			ST_MISS:   state_next = mau_req_ack ? ST_ACK : ST_FILL;
			ST_FILL:   if (mau_req_ack) state_next = ST_ACK;
			ST_ACK:    state_next = ST_IDLE;
			default:   state_next = ST_INIT;
		endcase
	end

	// ----------------------------
	// Request and fill registers
	// ----------------------------
	always_ff @(posedge clk) begin
		if (accept)
			req_r <= core_addr;
		if (state == ST_LOOKUP)
			victim_r <= victim_way;
		if (fill_we)
			fill_line_r <= mau_ack_data;
	end

	// Array control
	assign rd_en   = accept;
	assign rd_idx  = core_addr.idx;
	assign req_tag = req_r.tag;
	assign clr_en  = (state == ST_INIT);
	assign clr_idx = init_cnt;

	// MAU request, line aligned
	assign mau_addr     = '{tag: req_r.tag, idx: req_r.idx, offset: '0};
	assign mau_req_addr = mau_addr;
	assign mau_req_val  = miss_now || (state == ST_MISS) || (state == ST_FILL);

	assign fill_we   = mau_req_val && mau_req_ack;
	// Victim comes straight from the LRU when the MAU answers at once
	assign fill_way  = (state == ST_LOOKUP) ? victim_way : victim_r;
	assign touch     = hit_now || fill_we;
	assign touch_way = hit_now ? lookup.hit_way : fill_way;

	// Core response
	assign core_req_ack  = hit_now || (state == ST_ACK);
	assign ack_line      = (state == ST_ACK) ? fill_line_r : rd_line;
	assign word_sel      = req_r.offset[`CORE_OFFSET_WIDTH-1:2];
	assign core_ack_data = ack_line[word_sel * `CORE_DATA_WIDTH +: `CORE_DATA_WIDTH];

endmodule

//--- hw/l1i_lru.sv
// ----------------------------
// L1I LRU
// Per-set age counters and victim choice
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module l1i_lru
	import l1i_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          rd_en,
	input  logic [`CORE_IDX_WIDTH-1:0]    rd_idx,
	input  logic                          clr_en,
	input  logic [`CORE_IDX_WIDTH-1:0]    clr_idx,
	input  l1i_lookup_t                   lookup,
	input  logic                          touch,
	input  logic [`L1_WAY_IDX_WIDTH-1:0]  touch_way,
	output logic [`L1_WAY_IDX_WIDTH-1:0]  victim_way
);

	// Age 0 is youngest
	logic [`L1_WAY_IDX_WIDTH-1:0]   ages [`L1_SET_NUM][`L1_WAY_NUM];
	logic [`L1_WAY_IDX_WIDTH-1:0]   row [`L1_WAY_NUM];
	logic [`CORE_IDX_WIDTH-1:0]     idx_r;
	logic                           has_invalid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx_r <= '0;
		else if (rd_en)
			idx_r <= rd_idx;
	end

	always_comb begin
		for (int w = 0; w < `L1_WAY_NUM; w++)
			row[w] = ages[idx_r][w];
	end

	// ----------------------------
	// Age update
	// ----------------------------
	always_ff @(posedge clk) begin
		if (clr_en) begin
			for (int w = 0; w < `L1_WAY_NUM; w++)
				ages[clr_idx][w] <= `L1_WAY_IDX_WIDTH'(w);
		end else if (touch) begin
			for (int w = 0; w < `L1_WAY_NUM; w++) begin
				if (`L1_WAY_IDX_WIDTH'(w) == touch_way)
					ages[idx_r][w] <= '0;
				else if (row[w] < row[touch_way])
					ages[idx_r][w] <= row[w] + 1'b1;
			end
		end
	end

	// Invalid ways first, lowest number wins
	assign has_invalid = ~&lookup.valid_vect;

	always_comb begin
		victim_way = '0;
		if (has_invalid) begin
			for (int w = `L1_WAY_NUM - 1; w >= 0; w--) begin
				if (!lookup.valid_vect[w])
					victim_way = `L1_WAY_IDX_WIDTH'(w);
			end
		end else begin
			for (int w = 0; w < `L1_WAY_NUM; w++) begin
				if (row[w] == `L1_WAY_IDX_WIDTH'(`L1_WAY_NUM - 1))
					victim_way = `L1_WAY_IDX_WIDTH'(w);
			end
		end
	end

endmodule

//--- hw/l1i_data_array.sv
// ----------------------------
// L1I data array
// Line storage per way
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module l1i_data_array (
	input  logic                          clk,
	input  logic                          rd_en,
	input  logic [`CORE_IDX_WIDTH-1:0]    rd_idx,
	input  logic [`L1_WAY_IDX_WIDTH-1:0]  hit_way,
	input  logic                          fill_we,
	input  logic [`L1_WAY_IDX_WIDTH-1:0]  fill_way,
	input  logic [`L1_LINE_SIZE-1:0]      fill_data,
	output logic [`L1_LINE_SIZE-1:0]      rd_line
);

	logic [`L1_LINE_SIZE-1:0]     lines [`L1_SET_NUM][`L1_WAY_NUM];
	logic [`L1_LINE_SIZE-1:0]     rows_r [`L1_WAY_NUM];
	logic [`CORE_IDX_WIDTH-1:0]   idx_r;

	// All ways read together, fill goes to the set last read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			idx_r <= rd_idx;
			for (int w = 0; w < `L1_WAY_NUM; w++)
				rows_r[w] <= lines[rd_idx][w];
		end
		if (fill_we)
			lines[idx_r][fill_way] <= fill_data;
	end

	assign rd_line = rows_r[hit_way];

endmodule

//--- hw/l1i_tag_array.sv
// ----------------------------
// L1I tag array
// Tag/valid storage and tag compare
// ----------------------------
`timescale 1ns/1ps

`include "l1i_config.svh"

module l1i_tag_array
	import l1i_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          rd_en,
	input  logic [`CORE_IDX_WIDTH-1:0]    rd_idx,
	input  logic [`CORE_TAG_WIDTH-1:0]    req_tag,
	input  logic                          clr_en,
	input  logic [`CORE_IDX_WIDTH-1:0]    clr_idx,
	input  logic                          fill_we,
	input  logic [`L1_WAY_IDX_WIDTH-1:0]  fill_way,
	output l1i_lookup_t                   lookup
);

	l1i_tag_entry_t               tags [`L1_SET_NUM][`L1_WAY_NUM];
	l1i_tag_entry_t               row_r [`L1_WAY_NUM];
	logic [`CORE_IDX_WIDTH-1:0]   idx_r;

	// Set of the request in flight, used by the fill
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx_r <= '0;
		else if (rd_en)
			idx_r <= rd_idx;
	end

	always_ff @(posedge clk) begin
		if (clr_en) begin
			for (int w = 0; w < `L1_WAY_NUM; w++)
				tags[clr_idx][w] <= '0;
		end else if (fill_we) begin
			tags[idx_r][fill_way] <= '{valid: 1'b1, tag: req_tag};
		end
		if (rd_en) begin
			for (int w = 0; w < `L1_WAY_NUM; w++)
				row_r[w] <= tags[rd_idx][w];
		end
	end

	// Compare all ways, encode the matching one
	always_comb begin
		lookup = '0;
		for (int w = 0; w < `L1_WAY_NUM; w++) begin
			lookup.valid_vect[w] = row_r[w].valid;
			if (row_r[w].valid && (row_r[w].tag == req_tag)) begin
				lookup.hit     = 1'b1;
				lookup.hit_way = `L1_WAY_IDX_WIDTH'(w);
			end
		end
	end

endmodule

//--- hw/l1i_pkg.sv
// ----------------------------
// L1I types
// Address, tag entry and lookup structs, control states
// ----------------------------

`include "l1i_config.svh"

package l1i_pkg;

	// Fetch address split into its cache fields
	typedef struct packed {
		logic [`CORE_TAG_WIDTH-1:0]    tag;
		logic [`CORE_IDX_WIDTH-1:0]    idx;
		logic [`CORE_OFFSET_WIDTH-1:0] offset;
	} l1i_addr_t;

	// One tag RAM entry
	typedef struct packed {
		logic                       valid;
		logic [`CORE_TAG_WIDTH-1:0] tag;
	} l1i_tag_entry_t;

	// Tag compare result for the set being looked up
	typedef struct packed {
		logic                         hit;
		logic [`L1_WAY_IDX_WIDTH-1:0] hit_way;
		logic [`L1_WAY_NUM-1:0]       valid_vect;
	} l1i_lookup_t;

	typedef enum logic [2:0] {
		ST_INIT,
		ST_IDLE,
		ST_LOOKUP,
		ST_MISS,
		ST_FILL,
		ST_ACK
	} l1i_state_e;

endpackage

//--- include/l1i_config.svh
// ----------------------------
// L1I configuration
// Cache geometry and bus widths
// ----------------------------

`ifndef L1I_CONFIG_SVH
`define L1I_CONFIG_SVH

// Core fetch interface
`define CORE_ADDR_WIDTH   32
`define CORE_DATA_WIDTH   32

// Cache geometry
`define L1_LINE_SIZE      128
`define L1_WAY_NUM        4
`define L1_SET_NUM        16

// Address split, tag + idx + offset = address width
`define CORE_OFFSET_WIDTH 4
`define CORE_IDX_WIDTH    4
`define CORE_TAG_WIDTH    24

`define L1_WAY_IDX_WIDTH  2

`endif
